// File: sim.f
+incdir+include
verilog/gat_pkg.sv
verilog/gat_bram.sv
verilog/spmm_engine.sv
verilog/dmvm_unit.sv
verilog/gat_core.sv
dv/gat_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build with Verilator, run, then look for the pass message in the log
cd "$(dirname "$0")" &&
verilator --binary --timing -f sim.f --top-module gat_tb -o gat_sim > build.log 2>&1 &&
./obj_dir/gat_sim > sim.log 2>&1 ||
{ echo "Build or simulation failed, see build.log and sim.log"; exit 1; }
grep -q "ALL TESTS PASSED" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }

// File: dv/gat_tb.sv
/*
 * Directed testbench for the graph-attention core. Builds each graph in
 * local memory images, loads them through the write ports, runs the core
 * and compares every result word against a reference model.
 */
`include "gat_consts.svh"

module gat_tb;
  import gat_pkg::*;

  localparam int NODES       = `GAT_NUM_NODES;
  localparam int FEAT_OUT    = `GAT_FEAT_OUT;
  localparam int W_BASE      = `GAT_FEAT_IN * `GAT_FEAT_OUT;
  localparam int RES_PER     = `GAT_RES_PER_NODE;
  localparam int LEAK_DIV    = 1 << `GAT_LEAK_SHIFT;
  localparam int NUM_TESTS   = 5;
  localparam int RUN_CYCLES  = NODES * (2 + 4 * 8);
  localparam int TEST_CYCLES = RUN_CYCLES * 2 + 200;

  logic       clk = 1'b0;
  logic       rst;
  logic       h_data_bram_load_done;
  logic       h_node_info_bram_load_done;
  logic       wgt_bram_load_done;
  logic       h_data_bram_ena;
  logic       h_data_bram_wea;
  h_addr_t    h_data_bram_addra;
  h_word_t    h_data_bram_din;
  logic       h_node_info_bram_ena;
  logic       h_node_info_bram_wea;
  node_addr_t h_node_info_bram_addra;
  node_info_t h_node_info_bram_din;
  logic       wgt_bram_ena;
  logic       wgt_bram_wea;
  w_addr_t    wgt_bram_addra;
  data_t      wgt_bram_din;
  res_addr_t  feat_bram_addrb;
  res_t       feat_bram_dout;
  logic       gat_ready;

  // Host-side images of the three input memories
  h_word_t    h_img [`GAT_H_DEPTH];
  node_info_t info_img [NODES];
  data_t      w_img [`GAT_W_DEPTH];
  int         wh_exp [NODES][FEAT_OUT];
  int         score_exp [NODES];
  int         neg_scores;
  int         errors = 0;

  gat_core DUT (.*);

  always #10 clk = ~clk;

  // ======================================================================
  // Compare tasks
  // ======================================================================
  task automatic check_res(input res_t got, input res_t exp, input string what);
    if (got !== exp) begin
      errors++;
      $display("[ERROR] %0t: %s got %0d, expected %0d", $time, what, got, exp);
    end
  endtask

  task automatic check_ready(input logic exp, input string what);
    @(negedge clk);
    if (gat_ready !== exp) begin
      errors++;
      $display("[ERROR] %0t: gat_ready %s is %b, expected %b", $time, what, gat_ready, exp);
    end
  endtask

  // ======================================================================
  // Stimulus builders and host port drivers
  // ======================================================================
  task automatic make_graph(input int mode);
    int p;
    int len;
    int col;
    int val;
    p = 0;
    for (int n = 0; n < NODES; n++) begin
      case (mode)
        0: len = n % 3 + 1;
        1: len = (n % 4 == 0) ? 8 : ((n % 4 == 2) ? 2 : 0);
        default: len = int'($urandom_range(4, 0));
      endcase
      info_img[n] = {len[`GAT_ROW_LEN_W-1:0], n == NODES - 1};
      for (int j = 0; j < len; j++) begin
        col = (mode == 2) ? int'($urandom_range(7, 0)) : (n + j) % `GAT_FEAT_IN;
        case (mode)
          0: val = n + j + 1;
          1: val = (n * 5 + j * 3) % 17 - 8;
          default: val = int'($urandom);
        endcase
        h_img[p] = {col[`GAT_COL_W-1:0], val[`GAT_DATA_W-1:0]};
        p++;
      end
    end
    // Unused tail of H
    for (int i = p; i < `GAT_H_DEPTH; i++) begin
      h_img[i] = h_word_t'(i * 37 + 5);
    end
  endtask

  task automatic make_weights(input int mode);
    int a_mix [FEAT_OUT] = '{2, -3, 1, -1};
    for (int i = 0; i < W_BASE; i++) begin
      case (mode)
        0: w_img[i] = data_t'(i / FEAT_OUT + i % FEAT_OUT + 1);
        1: w_img[i] = data_t'((i * 3) % 7 - 3);
        default: w_img[i] = data_t'($urandom);
      endcase
    end
    for (int k = 0; k < FEAT_OUT; k++) begin
      case (mode)
        0: w_img[W_BASE + k] = data_t'(k + 1);
        1: w_img[W_BASE + k] = data_t'(a_mix[k]);
        default: w_img[W_BASE + k] = data_t'($urandom);
      endcase
    end
  endtask

  // All three memories written in parallel, one word per cycle
  task automatic load_all();
    for (int i = 0; i < `GAT_H_DEPTH; i++) begin
      @(posedge clk);
      h_data_bram_ena        <= 1'b1;
      h_data_bram_wea        <= 1'b1;
      h_data_bram_addra      <= h_addr_t'(i);
      h_data_bram_din        <= h_img[i];
      h_node_info_bram_ena   <= (i < NODES);
      h_node_info_bram_wea   <= (i < NODES);
      h_node_info_bram_addra <= node_addr_t'(i);
      h_node_info_bram_din   <= info_img[i % NODES];
      wgt_bram_ena           <= (i < `GAT_W_DEPTH);
      wgt_bram_wea           <= (i < `GAT_W_DEPTH);
      wgt_bram_addra         <= w_addr_t'(i);
      wgt_bram_din           <= w_img[i % `GAT_W_DEPTH];
    end
    @(posedge clk);
    h_data_bram_ena      <= 1'b0;
    h_data_bram_wea      <= 1'b0;
    h_node_info_bram_ena <= 1'b0;
    h_node_info_bram_wea <= 1'b0;
    wgt_bram_ena         <= 1'b0;
    wgt_bram_wea         <= 1'b0;
  endtask

  task automatic set_flags(input logic v);
    @(posedge clk);
    h_data_bram_load_done      <= v;
    h_node_info_bram_load_done <= v;
    wgt_bram_load_done         <= v;
  endtask

  // Poll gat_ready on falling edges
  task automatic wait_ready();
    do begin
      @(negedge clk);
    end while (gat_ready !== 1'b1);
  endtask

  task automatic read_res(input res_addr_t addr, output res_t data);
    @(posedge clk);
    feat_bram_addrb <= addr;
    @(posedge clk);
    @(negedge clk);
    data = feat_bram_dout;
  endtask

  // ======================================================================
  // Reference model
  // ======================================================================
  task automatic run_model();
    int p;
    int len;
    int col;
    int val;
    int raw;
    p = 0;
    neg_scores = 0;
    for (int n = 0; n < NODES; n++) begin
      len = int'(info_img[n][`GAT_ROW_LEN_W:1]);
      for (int k = 0; k < FEAT_OUT; k++) begin
        wh_exp[n][k] = 0;
      end
      for (int j = 0; j < len; j++) begin
        col = int'(h_img[p][`GAT_COL_W+`GAT_DATA_W-1 -: `GAT_COL_W]);
        val = int'(data_t'(h_img[p][`GAT_DATA_W-1:0]));
        for (int k = 0; k < FEAT_OUT; k++) begin
          wh_exp[n][k] += val * int'(w_img[col * FEAT_OUT + k]);
        end
        p++;
      end
      raw = 0;
      for (int k = 0; k < FEAT_OUT; k++) begin
        raw += int'(w_img[W_BASE + k]) * wh_exp[n][k];
      end
      // Negative scores are scaled down, rounding toward minus infinity
      if (raw < 0) begin
        neg_scores++;
        score_exp[n] = (raw - (LEAK_DIV - 1)) / LEAK_DIV;
      end else begin
        score_exp[n] = raw;
      end
    end
  endtask

  task automatic check_results();
    res_t got;
    res_t exp;
    for (int n = 0; n < NODES; n++) begin
      for (int s = 0; s < RES_PER; s++) begin
        read_res(res_addr_t'(n * RES_PER + s), got);
        exp = (s < FEAT_OUT) ? res_t'(wh_exp[n][s]) : res_t'(score_exp[n]);
        check_res(got, exp, $sformatf("node %0d word %0d", n, s));
      end
    end
  endtask

  task automatic load_and_run(input int graph_mode, input int weight_mode);
    set_flags(1'b0);
    make_graph(graph_mode);
    make_weights(weight_mode);
    load_all();
    set_flags(1'b1);
    wait_ready();
    run_model();
    check_results();
  endtask

  // ======================================================================
  // Directed tests
  // ======================================================================
  task automatic reset_and_ready();
    check_ready(1'b0, "after reset");
    make_graph(0);
    make_weights(0);
    load_all();
    @(posedge clk);
    h_data_bram_load_done      <= 1'b1;
    h_node_info_bram_load_done <= 1'b1;
    // Longer than any full run of this graph
    repeat (RUN_CYCLES) @(posedge clk);
    check_ready(1'b0, "with one flag low");
    @(posedge clk);
    wgt_bram_load_done <= 1'b1;
    wait_ready();
    check_ready(1'b1, "after a run");
    @(posedge clk);
    h_node_info_bram_load_done <= 1'b0;
    @(posedge clk);
    check_ready(1'b0, "after a flag drop");
  endtask

  task automatic small_graph();
    load_and_run(0, 0);
  endtask

  task automatic negative_scores();
    load_and_run(0, 1);
    if (neg_scores == 0) begin
      errors++;
      $display("Negative score test data produced no negative score");
    end
  endtask

  task automatic edge_rows();
    load_and_run(1, 1);
  endtask

  task automatic random_rerun();
    load_and_run(2, 2);
  endtask

  initial begin
    void'($urandom(32'he1279c85));
    rst                        = 1'b1;
    h_data_bram_load_done      = 1'b0;
    h_node_info_bram_load_done = 1'b0;
    wgt_bram_load_done         = 1'b0;
    h_data_bram_ena            = 1'b0;
    h_data_bram_wea            = 1'b0;
    h_data_bram_addra          = '0;
    h_data_bram_din            = '0;
    h_node_info_bram_ena       = 1'b0;
    h_node_info_bram_wea       = 1'b0;
    h_node_info_bram_addra     = '0;
    h_node_info_bram_din       = '0;
    wgt_bram_ena               = 1'b0;
    wgt_bram_wea               = 1'b0;
    wgt_bram_addra             = '0;
    wgt_bram_din               = '0;
    feat_bram_addrb            = '0;
    repeat (4) @(posedge clk);
    rst <= 1'b0;
    reset_and_ready();
    small_graph();
    negative_scores();
    edge_rows();
    random_rerun();
    $display("Checks finished with %0d errors", errors);
    if (errors == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

  // Watchdog sized from the worst-case run of every test
  initial begin
    repeat (NUM_TESTS * TEST_CYCLES + 4) @(posedge clk);
    $display("Timeout: the tests did not finish within %0d cycles",
             NUM_TESTS * TEST_CYCLES + 4);
    $display("SOME TESTS FAILED");
    $finish;
  end

endmodule

// File: verilog/gat_core.sv
/*
 * Graph-attention layer core. The host fills H, row info and weights
 * through the write ports, raises the load-done flags, waits for
 * gat_ready and then reads results through feat_bram_addrb.
 */
`include "gat_consts.svh"

module gat_core (
  input  logic                clk,
  input  logic                rst,
  input  logic                h_data_bram_load_done,
  input  logic                h_node_info_bram_load_done,
  input  logic                wgt_bram_load_done,

  input  logic                h_data_bram_ena,
  input  logic                h_data_bram_wea,
  input  gat_pkg::h_addr_t    h_data_bram_addra,
  input  gat_pkg::h_word_t    h_data_bram_din,

  input  logic                h_node_info_bram_ena,
  input  logic                h_node_info_bram_wea,
  input  gat_pkg::node_addr_t h_node_info_bram_addra,
  input  gat_pkg::node_info_t h_node_info_bram_din,

  input  logic                wgt_bram_ena,
  input  logic                wgt_bram_wea,
  input  gat_pkg::w_addr_t    wgt_bram_addra,
  input  gat_pkg::data_t      wgt_bram_din,

  input  gat_pkg::res_addr_t  feat_bram_addrb,
  output gat_pkg::res_t       feat_bram_dout,
  output logic                gat_ready
);
  import gat_pkg::*;

  h_addr_t    h_addr;
  h_word_t    h_dout;
  node_addr_t info_addr;
  node_info_t info_dout;
  w_addr_t    w_addr;
  data_t      w_dout;
  logic       wh_valid;
  wh_vec_t    wh;
  logic       wh_last;
  logic       wh_ready;
  logic       res_wea;
  res_addr_t  res_addra;
  res_t       res_din;

  // ======================================================================
  // Memories
  // ======================================================================
  gat_bram #(.WIDTH($bits(h_word_t)), .DEPTH(`GAT_H_DEPTH)) u_h_data_bram (
    .clk   (clk),
    .wea   (h_data_bram_ena & h_data_bram_wea),
    .addra (h_data_bram_addra),
    .din   (h_data_bram_din),
    .addrb (h_addr),
    .doutb (h_dout)
  );

  gat_bram #(.WIDTH($bits(node_info_t)), .DEPTH(`GAT_NUM_NODES)) u_node_info_bram (
    .clk   (clk),
    .wea   (h_node_info_bram_ena & h_node_info_bram_wea),
    .addra (h_node_info_bram_addra),
    .din   (h_node_info_bram_din),
    .addrb (info_addr),
    .doutb (info_dout)
  );

  gat_bram #(.WIDTH($bits(data_t)), .DEPTH(`GAT_W_DEPTH)) u_wgt_bram (
    .clk   (clk),
    .wea   (wgt_bram_ena & wgt_bram_wea),
    .addra (wgt_bram_addra),
    .din   (wgt_bram_din),
    .addrb (w_addr),
    .doutb (w_dout)
  );

  gat_bram #(.WIDTH($bits(res_t)), .DEPTH(`GAT_RES_DEPTH)) u_feat_bram (
    .clk   (clk),
    .wea   (res_wea),
    .addra (res_addra),
    .din   (res_din),
    .addrb (feat_bram_addrb),
    .doutb (feat_bram_dout)
  );

  // ======================================================================
  // Compute stages
  // ======================================================================
  spmm_engine u_spmm (
    .clk       (clk),
    .rst       (rst),
    .start     (h_data_bram_load_done & h_node_info_bram_load_done & wgt_bram_load_done),
    .h_addr    (h_addr),
    .h_dout    (h_dout),
    .info_addr (info_addr),
    .info_dout (info_dout),
    .w_addr    (w_addr),
    .w_dout    (w_dout),
    .wh_valid  (wh_valid),
    .wh        (wh),
    .wh_last   (wh_last),
    .wh_ready  (wh_ready),
    // Engine status is not needed at this level
    .busy      ()
  );

  dmvm_unit u_dmvm (
    .clk       (clk),
    .rst       (rst),
    .wgt_wea   (wgt_bram_ena & wgt_bram_wea),
    .wgt_addra (wgt_bram_addra),
    .wgt_din   (wgt_bram_din),
    .wh_valid  (wh_valid),
    .wh        (wh),
    .wh_last   (wh_last),
    .wh_ready  (wh_ready),
    .load_done (h_data_bram_load_done & h_node_info_bram_load_done & wgt_bram_load_done),
    .res_wea   (res_wea),
    .res_addra (res_addra),
    .res_din   (res_din),
    .gat_ready (gat_ready)
  );

endmodule

// File: verilog/dmvm_unit.sv
/*
 * Attention unit. Snoops the a vector from the weight writes, scores
 * each WH against it with leaky ReLU, and writes WH plus score to the
 * result memory. Raises gat_ready after the flagged node.
 */
`include "gat_consts.svh"

module dmvm_unit (
  input  logic               clk,
  input  logic               rst,
  input  logic               wgt_wea,
  input  gat_pkg::w_addr_t   wgt_addra,
  input  gat_pkg::data_t     wgt_din,
  input  logic               wh_valid,
  input  gat_pkg::wh_vec_t   wh,
  input  logic               wh_last,
  output logic               wh_ready,
  input  logic               load_done,
  output logic               res_wea,
  output gat_pkg::res_addr_t res_addra,
  output gat_pkg::res_t      res_din,
  output logic               gat_ready
);
  import gat_pkg::*;

  localparam int K_W   = $clog2(`GAT_FEAT_OUT);
  localparam int CNT_W = $clog2(`GAT_RES_PER_NODE);
  localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(`GAT_RES_PER_NODE - 1);
  localparam w_addr_t A_BASE = w_addr_t'(`GAT_FEAT_IN * `GAT_FEAT_OUT);

  typedef enum logic [1:0] {D_IDLE, D_PROD, D_SUM, D_WR} state_t;

  state_t           state;
  logic [CNT_W-1:0] cnt;
  logic             last_q;
  res_addr_t        res_ptr;

  data_t            a_q [`GAT_FEAT_OUT];
  w_addr_t          a_off;
  wh_vec_t          wh_q;
  res_t             prod [`GAT_FEAT_OUT];
  res_t             raw;
  res_t             score;

  // a coefficients sit right after W in the weight space
  assign a_off = wgt_addra - A_BASE;

  always_ff @(posedge clk) begin
    if (wgt_wea && wgt_addra >= A_BASE && a_off < `GAT_FEAT_OUT) begin
      a_q[a_off[K_W-1:0]] <= wgt_din;
    end
  end

  always_comb begin
    raw = '0;
    for (int i = 0; i < `GAT_FEAT_OUT; i++) begin
      raw = raw + prod[i];
    end
  end

  // ======================================================================
  // Score pipeline, products then sum with leaky ReLU
  // ======================================================================
  always_ff @(posedge clk) begin
    if (state == D_IDLE && wh_valid) begin
      wh_q <= wh;
    end
    if (state == D_PROD) begin
      for (int i = 0; i < `GAT_FEAT_OUT; i++) begin
        prod[i] <= res_t'(a_q[i]) * res_t'(wh_q[i]);
      end
    end
    if (state == D_SUM) begin
      score <= raw[`GAT_RES_W-1] ? (raw >>> `GAT_LEAK_SHIFT) : raw;
    end
  end

  // ======================================================================
  // Control and result writes
  // ======================================================================
  always_ff @(posedge clk) begin
    if (rst) begin
      state     <= D_IDLE;
      cnt       <= '0;
      last_q    <= 1'b0;
      res_ptr   <= '0;
      gat_ready <= 1'b0;
    end else begin
      case (state)
        D_IDLE: begin
          if (wh_valid) begin
            last_q <= wh_last;
            state  <= D_PROD;
          end
        end
        D_PROD: state <= D_SUM;
        D_SUM: begin
          cnt   <= '0;
          state <= D_WR;
        end
        D_WR: begin
          res_ptr <= res_ptr + 1'b1;
          if (cnt == CNT_LAST) begin
            state <= D_IDLE;
            if (last_q) begin
              gat_ready <= 1'b1;
            end
          end else begin
            cnt <= cnt + 1'b1;
          end
        end
        default: state <= D_IDLE;
      endcase
      // Dropped flags end the run and rewind the result pointer
      if (!load_done) begin
        gat_ready <= 1'b0;
        res_ptr   <= '0;
      end
    end
  end

  assign wh_ready  = (state == D_IDLE);
  assign res_wea   = (state == D_WR);
  assign res_addra = res_ptr;
  // Features first, score in the last slot
  assign res_din   = (cnt < CNT_W'(`GAT_FEAT_OUT)) ? res_t'(wh_q[cnt[K_W-1:0]]) : score;

endmodule

// File: verilog/spmm_engine.sv
/*
 * Sparse H times dense W. Walks the nodes in order, reads each row
 * length, then multiply-accumulates every nonzero against its W row.
 * Each finished WH is offered on a valid/ready handshake.
 */
`include "gat_consts.svh"

module spmm_engine (
  input  logic                clk,
  input  logic                rst,
  input  logic                start,
  output gat_pkg::h_addr_t    h_addr,
  input  gat_pkg::h_word_t    h_dout,
  output gat_pkg::node_addr_t info_addr,
  input  gat_pkg::node_info_t info_dout,
  output gat_pkg::w_addr_t    w_addr,
  input  gat_pkg::data_t      w_dout,
  output logic                wh_valid,
  output gat_pkg::wh_vec_t    wh,
  output logic                wh_last,
  input  logic                wh_ready,
  output logic                busy
);
  import gat_pkg::*;

  localparam int K_W = $clog2(`GAT_FEAT_OUT);
  localparam logic [K_W-1:0] K_LAST = K_W'(`GAT_FEAT_OUT - 1);

  typedef enum logic [2:0] {S_IDLE, S_INFO, S_ROW, S_MAC, S_TAIL, S_OUT} state_t;

  state_t                    state;
  node_addr_t                node;
  h_addr_t                   hptr;
  logic [K_W-1:0]            k;
  logic [`GAT_ROW_LEN_W-1:0] rem;
  logic                      last_flag;
  logic                      ran;

  logic                      mac_vld;
  logic [K_W-1:0]            mac_k;
  data_t                     mac_val;
  wh_vec_t                   acc;

  logic [`GAT_COL_W-1:0]     col;
  data_t                     val;
  logic [`GAT_ROW_LEN_W-1:0] row_len;
  logic                      issue;

  assign col     = h_dout[`GAT_COL_W+`GAT_DATA_W-1 -: `GAT_COL_W];
  assign val     = h_dout[`GAT_DATA_W-1:0];
  assign row_len = info_dout[`GAT_ROW_LEN_W:1];

  // One weight read per cycle while a row has nonzeros left
  assign issue = (state == S_MAC) || (state == S_ROW && row_len != '0);

  // Fetch the next H word early so it lands with the next k of 0
  assign h_addr    = (state == S_MAC && k == K_LAST) ? hptr + 1'b1 : hptr;
  assign info_addr = node;
  assign w_addr    = w_addr_t'(col) * w_addr_t'(`GAT_FEAT_OUT) + w_addr_t'(k);

  assign wh_valid = (state == S_OUT);
  assign wh       = acc;
  assign wh_last  = last_flag;
  assign busy     = (state != S_IDLE);

  // ======================================================================
  // Control FSM
  // ======================================================================
  always_ff @(posedge clk) begin
    if (rst) begin
      state     <= S_IDLE;
      node      <= '0;
      hptr      <= '0;
      k         <= '0;
      rem       <= '0;
      last_flag <= 1'b0;
      ran       <= 1'b0;
      mac_vld   <= 1'b0;
    end else begin
      mac_vld <= issue;
      case (state)
        S_IDLE: begin
          // Re-arm only after the done flags have dropped
          if (!start) begin
            ran <= 1'b0;
          end else if (!ran) begin
            node  <= '0;
            hptr  <= '0;
            state <= S_INFO;
          end
        end
        S_INFO: begin
          k     <= '0;
          state <= S_ROW;
        end
        S_ROW: begin
          last_flag <= info_dout[0];
          rem       <= row_len - 1'b1;
          if (row_len == '0) begin
            state <= S_OUT;
          end else begin
            k     <= k + 1'b1;
            state <= S_MAC;
          end
        end
        S_MAC: begin
          if (k == K_LAST) begin
            k    <= '0;
            hptr <= hptr + 1'b1;
            if (rem == '0) begin
              state <= S_TAIL;
            end else begin
              rem <= rem - 1'b1;
            end
          end else begin
            k <= k + 1'b1;
          end
        end
        S_TAIL: begin
          state <= S_OUT;
        end
        S_OUT: begin
          if (wh_ready) begin
            if (last_flag) begin
              ran   <= 1'b1;
              state <= S_IDLE;
            end else begin
              node  <= node + 1'b1;
              state <= S_INFO;
            end
          end
        end
        default: state <= S_IDLE;
      endcase
    end
  end

  // ======================================================================
  // MAC datapath, weight arrives one cycle after its address
  // ======================================================================
  always_ff @(posedge clk) begin
    mac_k   <= k;
    mac_val <= val;
    if (state == S_INFO) begin
      acc <= '0;
    end else if (mac_vld) begin
      acc[mac_k] <= acc[mac_k] + mac_val * w_dout;
    end
  end

endmodule

// File: verilog/gat_bram.sv
/*
 * Simple dual-port block RAM. Port A writes one word per cycle,
 * port B returns the addressed word one clock after the address.
 */
module gat_bram #(
  parameter int WIDTH = 8,
  parameter int DEPTH = 16
) (
  input  logic                     clk,
  input  logic                     wea,
  input  logic [$clog2(DEPTH)-1:0] addra,
  input  logic [WIDTH-1:0]         din,
  input  logic [$clog2(DEPTH)-1:0] addrb,
  output logic [WIDTH-1:0]         doutb
);

  logic [WIDTH-1:0] mem [DEPTH];

  always_ff @(posedge clk) begin
    if (wea) begin
      mem[addra] <= din;
    end
  end

  // Read-first on a same-address collision
  always_ff @(posedge clk) begin
    doutb <= mem[addrb];
  end

endmodule

// File: verilog/gat_pkg.sv
/*
 * Data types shared by the core, the SpMM engine and the attention unit.
 * Sizes come from the constants header.
 */
`include "gat_consts.svh"

package gat_pkg;

  typedef logic signed [`GAT_DATA_W-1:0] data_t;

  // Column index on top, value below
  typedef logic [`GAT_COL_W+`GAT_DATA_W-1:0] h_word_t;

  // Row length on top, last-node flag in bit 0
  typedef logic [`GAT_ROW_LEN_W:0] node_info_t;

  typedef logic signed [`GAT_ACC_W-1:0] acc_t;
  typedef acc_t [`GAT_FEAT_OUT-1:0] wh_vec_t;
  typedef logic signed [`GAT_RES_W-1:0] res_t;

  typedef logic [$clog2(`GAT_H_DEPTH)-1:0]   h_addr_t;
  typedef logic [$clog2(`GAT_NUM_NODES)-1:0] node_addr_t;
  typedef logic [$clog2(`GAT_W_DEPTH)-1:0]   w_addr_t;
  typedef logic [$clog2(`GAT_RES_DEPTH)-1:0] res_addr_t;

endpackage

// File: include/gat_consts.svh
/*
 * Configuration constants for the graph-attention layer core.
 * Include wherever a width or depth is needed; derived depths follow
 * from the base sizes, so only the first block should be edited.
 */
`ifndef GAT_CONSTS_SVH
`define GAT_CONSTS_SVH

// ======================================================================
// Base configuration
// ======================================================================
`define GAT_DATA_W        8
`define GAT_NUM_NODES     16
`define GAT_FEAT_IN       8
`define GAT_FEAT_OUT      4
`define GAT_H_DEPTH       64
`define GAT_COL_W         3
`define GAT_ROW_LEN_W     4
`define GAT_ACC_W         20
`define GAT_RES_W         32
`define GAT_LEAK_SHIFT    3

// ======================================================================
// Derived sizes
// ======================================================================
// W row-major by input feature, a vector appended after it
`define GAT_W_DEPTH       (`GAT_FEAT_IN * `GAT_FEAT_OUT + `GAT_FEAT_OUT)
// WH words plus one score per node
`define GAT_RES_PER_NODE  (`GAT_FEAT_OUT + 1)
`define GAT_RES_DEPTH     (`GAT_NUM_NODES * `GAT_RES_PER_NODE)

`endif
